/* logic/graph_cu_pkg.sv */
// Shared widths, job/edge/command/response structs and buffer status used by the sum unit and its testbench
package graph_cu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Vertex id and in-degree
	localparam int VERTEX_BITS = 16;

	// Edge value and accumulated sum
	localparam int DATA_BITS = 32;

	// Lane identity carried by commands and responses
	localparam int LANE_ID_BITS = 1;

	// Kernel lanes behind the shared write buffer
	localparam int NUM_LANES = 2;

	//////////////////////////////////////////////////////////////////////
	// Job and edge input
	//////////////////////////////////////////////////////////////////////

	// Vertex job held as a level by the environment
	typedef struct packed {
		logic                   valid;
		logic [VERTEX_BITS-1:0] id;
		logic [VERTEX_BITS-1:0] in_degree;
	} vertex_job_t;

	typedef struct packed {
		logic                 valid;
		logic [DATA_BITS-1:0] data;
	} edge_data_read_t;

	//////////////////////////////////////////////////////////////////////
	// Write commands and responses
	//////////////////////////////////////////////////////////////////////

	// Payload held in the write buffers without its valid bit
	typedef struct packed {
		logic [VERTEX_BITS-1:0]  index;
		logic [LANE_ID_BITS-1:0] lane_id;
		logic [DATA_BITS-1:0]    data;
	} write_payload_t;

	typedef struct packed {
		logic           valid;
		write_payload_t payload;
	} edge_data_write_t;

	// Returned by the outside, routed back by lane_id
	typedef struct packed {
		logic                    valid;
		logic [LANE_ID_BITS-1:0] lane_id;
		logic [VERTEX_BITS-1:0]  index;
	} write_response_t;

	// Status levels of any sync_fifo
	typedef struct packed {
		logic valid;
		logic full;
		logic alfull;
		logic empty;
	} buffer_status_t;

endpackage

/* logic/sync_fifo.sv */
// Synchronous circular FIFO with occupancy flags and a registered output for all buffers of the sum unit
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Pushes into a full buffer and pops from an empty one are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full   = (count == CNT_BITS'(DEPTH));
	assign alfull = (count >= CNT_BITS'(DEPTH - 2));
	assign empty  = (count == '0);

	//////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Output valid one cycle after an accepted pop
			valid <= do_pop;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Storage and read port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

/* logic/sum_kernel_control.sv */
// One compute lane that sums in_degree edge values per vertex job and queues the write command for the arbiter
`timescale 1ns/1ns

module sum_kernel_control #(
	parameter int LANE_ID     = 0,
	parameter int LOCAL_DEPTH = 8
) (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 enable_in,
	input  graph_cu_pkg::vertex_job_t            vertex_job,
	input  graph_cu_pkg::edge_data_read_t        edge_data,
	input  graph_cu_pkg::buffer_status_t         data_buffer_status,
	output logic                                 edge_data_request,
	input  graph_cu_pkg::buffer_status_t         write_buffer_status,
	input  logic                                 write_bus_grant,
	output logic                                 write_bus_request,
	output graph_cu_pkg::edge_data_write_t       edge_data_write_out,
	input  graph_cu_pkg::write_response_t        write_response,
	output logic [graph_cu_pkg::VERTEX_BITS-1:0] edge_count,
	output logic [graph_cu_pkg::VERTEX_BITS-1:0] response_count
);
	import graph_cu_pkg::*;

	logic                   enabled;
	vertex_job_t            job_latched;
	edge_data_read_t        edge_latched;
	buffer_status_t         data_status_latched;
	logic [DATA_BITS-1:0]   sum;
	logic [VERTEX_BITS-1:0] accum_count;
	logic                   last_edge;
	edge_data_write_t       command;
	write_payload_t         local_payload;
	buffer_status_t         local_status;
	logic                   grant_latched;

	//////////////////////////////////////////////////////////////////////
	// Enable and input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable_in;
		end
	end

	// Job and edge status hold while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_latched         <= '0;
			data_status_latched <= '{valid: 1'b0, full: 1'b0, alfull: 1'b0, empty: 1'b1};
		end else if (enabled) begin
			job_latched         <= vertex_job;
			data_status_latched <= data_buffer_status;
		end
	end

	// Edges already popped still drain when enable drops
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_latched <= '0;
		end else begin
			edge_latched <= edge_data;
		end
	end

	// Stop fetching edges when the command queue is nearly full
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_request <= 1'b0;
		end else begin
			edge_data_request <= enabled && job_latched.valid &&
				!data_status_latched.empty && !local_status.alfull;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Accumulation
	//////////////////////////////////////////////////////////////////////

	assign last_edge = edge_latched.valid && job_latched.valid &&
		(accum_count + 1'b1 == job_latched.in_degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum         <= '0;
			accum_count <= '0;
			command     <= '0;
		end else begin
			command.valid <= last_edge;
			if (last_edge) begin
				sum         <= '0;
				accum_count <= '0;
				// Final value folded in as the command is formed
				command.payload.index   <= job_latched.id;
				command.payload.lane_id <= LANE_ID_BITS'(LANE_ID);
				command.payload.data    <= sum + edge_latched.data;
			end else if (edge_latched.valid && job_latched.valid) begin
				sum         <= sum + edge_latched.data;
				accum_count <= accum_count + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Edge and response counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count     <= '0;
			response_count <= '0;
		end else begin
			if (edge_latched.valid) begin
				edge_count <= edge_count + 1'b1;
			end
			if (write_response.valid && (write_response.lane_id == LANE_ID_BITS'(LANE_ID))) begin
				response_count <= response_count + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Local command queue and write bus side
	//////////////////////////////////////////////////////////////////////

	// A grant that meets a nearly full shared buffer is dropped and the request rises again
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_latched     <= 1'b0;
			write_bus_request <= 1'b0;
		end else begin
			grant_latched     <= enabled && write_bus_grant && !write_buffer_status.alfull;
			write_bus_request <= enabled && !local_status.empty && !write_buffer_status.alfull;
		end
	end

	sync_fifo #(
		.WIDTH($bits(write_payload_t)),
		.DEPTH(LOCAL_DEPTH)
	) command_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (command.valid),
		.data_in (command.payload),
		.pop     (grant_latched),
		.data_out(local_payload),
		.valid   (local_status.valid),
		.full    (local_status.full),
		.alfull  (local_status.alfull),
		.empty   (local_status.empty)
	);

	assign edge_data_write_out.valid   = local_status.valid;
	assign edge_data_write_out.payload = local_payload;

endmodule

/* logic/write_bus_arbiter.sv */
// Round-robin arbiter that moves lane write commands into the shared buffer and routes responses back
`timescale 1ns/1ns

module write_bus_arbiter (
	input  logic                                                        clock,
	input  logic                                                        rstn,
	input  logic [graph_cu_pkg::NUM_LANES-1:0]                          write_bus_request,
	output logic [graph_cu_pkg::NUM_LANES-1:0]                          write_bus_grant,
	input  graph_cu_pkg::edge_data_write_t [graph_cu_pkg::NUM_LANES-1:0] lane_write,
	input  graph_cu_pkg::buffer_status_t                                write_buffer_status,
	output logic                                                        buffer_push,
	output graph_cu_pkg::edge_data_write_t                              buffer_data,
	input  graph_cu_pkg::write_response_t                               write_response_in,
	output graph_cu_pkg::write_response_t [graph_cu_pkg::NUM_LANES-1:0] lane_response
);
	import graph_cu_pkg::*;

	// Lane of a grant as it moves down the pipe
	typedef struct packed {
		logic                    valid;
		logic [LANE_ID_BITS-1:0] lane;
	} grant_tag_t;

	grant_tag_t              grant_next;
	grant_tag_t              grant_tag;
	grant_tag_t              pending_d1;
	grant_tag_t              pending_d2;
	logic [LANE_ID_BITS-1:0] last_lane;
	logic [LANE_ID_BITS-1:0] cand_lane;

	//////////////////////////////////////////////////////////////////////
	// Round-robin pick
	//////////////////////////////////////////////////////////////////////

	// Search starts just after the last granted lane
	always_comb begin
		grant_next = '0;
		cand_lane  = last_lane;
		for (int i = 1; i <= NUM_LANES; i++) begin
			cand_lane = LANE_ID_BITS'((int'(last_lane) + i) % NUM_LANES);
			if (!grant_next.valid && write_bus_request[cand_lane] &&
				!write_buffer_status.alfull) begin
				grant_next.valid = 1'b1;
				grant_next.lane  = cand_lane;
			end
		end
	end

	// Command valid follows the grant by two cycles
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_tag  <= '0;
			pending_d1 <= '0;
			pending_d2 <= '0;
			last_lane  <= LANE_ID_BITS'(NUM_LANES - 1);
		end else begin
			grant_tag  <= grant_next;
			pending_d1 <= grant_tag;
			pending_d2 <= pending_d1;
			if (grant_next.valid) begin
				last_lane <= grant_next.lane;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			write_bus_grant[i] = grant_tag.valid && (grant_tag.lane == LANE_ID_BITS'(i));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shared buffer push
	//////////////////////////////////////////////////////////////////////

	// A dropped grant leaves no valid command, so nothing is pushed
	assign buffer_push = pending_d2.valid && lane_write[pending_d2.lane].valid;

	always_comb begin
		buffer_data       = lane_write[pending_d2.lane];
		buffer_data.valid = buffer_push;
	end

	//////////////////////////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_response[i]       = write_response_in;
			lane_response[i].valid = write_response_in.valid &&
				(write_response_in.lane_id == LANE_ID_BITS'(i));
		end
	end

endmodule

/* logic/cu_sum_unit.sv */
// Top of the two-lane sum unit that joins edge buffers, kernels, arbiter and the shared write command buffer
`timescale 1ns/1ns

module cu_sum_unit #(
	parameter int EDGE_DEPTH  = 16,
	parameter int LOCAL_DEPTH = 8,
	parameter int WRITE_DEPTH = 8
) (
	input  logic                                                         clock,
	input  logic                                                         rstn,
	input  logic                                                         enable_in,
	input  graph_cu_pkg::vertex_job_t [graph_cu_pkg::NUM_LANES-1:0]      vertex_job,
	input  graph_cu_pkg::edge_data_read_t [graph_cu_pkg::NUM_LANES-1:0]  edge_data_in,
	input  logic                                                         write_cmd_pop,
	output graph_cu_pkg::edge_data_write_t                               write_cmd_out,
	input  graph_cu_pkg::write_response_t                                write_response_in,
	output logic [graph_cu_pkg::NUM_LANES-1:0][graph_cu_pkg::VERTEX_BITS-1:0] edge_count,
	output logic [graph_cu_pkg::NUM_LANES-1:0][graph_cu_pkg::VERTEX_BITS-1:0] response_count
);
	import graph_cu_pkg::*;

	edge_data_read_t  [NUM_LANES-1:0] edge_data;
	buffer_status_t   [NUM_LANES-1:0] edge_status;
	logic             [NUM_LANES-1:0] edge_data_request;
	logic             [NUM_LANES-1:0] write_bus_request;
	logic             [NUM_LANES-1:0] write_bus_grant;
	edge_data_write_t [NUM_LANES-1:0] lane_write;
	write_response_t  [NUM_LANES-1:0] lane_response;
	buffer_status_t                   write_status;
	logic                             buffer_push;
	edge_data_write_t                 buffer_data;

	//////////////////////////////////////////////////////////////////////
	// Per-lane edge buffer and kernel
	//////////////////////////////////////////////////////////////////////

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
		sync_fifo #(
			.WIDTH(DATA_BITS),
			.DEPTH(EDGE_DEPTH)
		) edge_buffer (
			.clock   (clock),
			.rstn    (rstn),
			.push    (edge_data_in[lane].valid),
			.data_in (edge_data_in[lane].data),
			.pop     (edge_data_request[lane]),
			.data_out(edge_data[lane].data),
			.valid   (edge_data[lane].valid),
			.full    (edge_status[lane].full),
			.alfull  (edge_status[lane].alfull),
			.empty   (edge_status[lane].empty)
		);

		assign edge_status[lane].valid = edge_data[lane].valid;

		sum_kernel_control #(
			.LANE_ID    (lane),
			.LOCAL_DEPTH(LOCAL_DEPTH)
		) kernel (
			.clock              (clock),
			.rstn               (rstn),
			.enable_in          (enable_in),
			.vertex_job         (vertex_job[lane]),
			.edge_data          (edge_data[lane]),
			.data_buffer_status (edge_status[lane]),
			.edge_data_request  (edge_data_request[lane]),
			.write_buffer_status(write_status),
			.write_bus_grant    (write_bus_grant[lane]),
			.write_bus_request  (write_bus_request[lane]),
			.edge_data_write_out(lane_write[lane]),
			.write_response     (lane_response[lane]),
			.edge_count         (edge_count[lane]),
			.response_count     (response_count[lane])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Arbiter and shared write command buffer
	//////////////////////////////////////////////////////////////////////

	write_bus_arbiter arbiter (
		.clock              (clock),
		.rstn               (rstn),
		.write_bus_request  (write_bus_request),
		.write_bus_grant    (write_bus_grant),
		.lane_write         (lane_write),
		.write_buffer_status(write_status),
		.buffer_push        (buffer_push),
		.buffer_data        (buffer_data),
		.write_response_in  (write_response_in),
		.lane_response      (lane_response)
	);

	sync_fifo #(
		.WIDTH($bits(write_payload_t)),
		.DEPTH(WRITE_DEPTH)
	) write_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (buffer_push),
		.data_in (buffer_data.payload),
		.pop     (write_cmd_pop),
		.data_out(write_cmd_out.payload),
		.valid   (write_cmd_out.valid),
		.full    (write_status.full),
		.alfull  (write_status.alfull),
		.empty   (write_status.empty)
	);

	assign write_status.valid = write_cmd_out.valid;

endmodule

/* tests/sum_lane_model.svh */
// Reference model of the two sum lanes that the sum unit testbench includes in its body
`ifndef SUM_LANE_MODEL_SVH
`define SUM_LANE_MODEL_SVH

// Job in flight per lane and the command it must produce
logic [VERTEX_BITS-1:0] model_job_id   [NUM_LANES];
logic [DATA_BITS-1:0]   model_job_sum  [NUM_LANES];
logic                   model_cmd_open [NUM_LANES];

// Running totals per lane
int model_edges [NUM_LANES];
int model_cmds  [NUM_LANES];
int model_resps [NUM_LANES];

function automatic void model_clear();
	for (int lane = 0; lane < NUM_LANES; lane++) begin
		model_job_id[lane]   = '0;
		model_job_sum[lane]  = '0;
		model_cmd_open[lane] = 1'b0;
		model_edges[lane]    = 0;
		model_cmds[lane]     = 0;
		model_resps[lane]    = 0;
	end
endfunction

function automatic void model_start_job(input int lane, input logic [VERTEX_BITS-1:0] id);
	model_job_id[lane]   = id;
	model_job_sum[lane]  = '0;
	model_cmd_open[lane] = 1'b1;
endfunction

// Sum wraps at DATA_BITS
function automatic void model_add_edge(input int lane, input logic [DATA_BITS-1:0] value);
	model_job_sum[lane] = model_job_sum[lane] + value;
	model_edges[lane]++;
endfunction

function automatic void model_close_job(input int lane);
	model_cmd_open[lane] = 1'b0;
	model_cmds[lane]++;
endfunction

function automatic void model_add_response(input int lane);
	model_resps[lane]++;
endfunction

`endif

/* tests/cu_sum_unit_tb.sv */
// Testbench for the two-lane sum unit with random jobs, edges, pops and responses checked against a model
`timescale 1ns/1ns

module cu_sum_unit_tb;
	import graph_cu_pkg::*;

	localparam int EDGE_DEPTH     = 16;
	localparam int LOCAL_DEPTH    = 8;
	localparam int WRITE_DEPTH    = 8;
	localparam int JOBS_PER_PHASE = 12;
	localparam int WAIT_LIMIT     = 2000;

	logic                                  clock;
	logic                                  rstn;
	logic                                  enable_in;
	vertex_job_t [NUM_LANES-1:0]           vertex_job;
	edge_data_read_t [NUM_LANES-1:0]       edge_data_in;
	logic                                  write_cmd_pop;
	edge_data_write_t                      write_cmd_out;
	write_response_t                       write_response_in;
	logic [NUM_LANES-1:0][VERTEX_BITS-1:0] edge_count;
	logic [NUM_LANES-1:0][VERTEX_BITS-1:0] response_count;

	integer          seed = 37894;
	int              cycle_count = 0;
	logic            hold_pops;
	write_response_t resp_q [$];
	int              resp_due_q [$];

	`include "sum_lane_model.svh"

	cu_sum_unit #(
		.EDGE_DEPTH (EDGE_DEPTH),
		.LOCAL_DEPTH(LOCAL_DEPTH),
		.WRITE_DEPTH(WRITE_DEPTH)
	) cu_sum_unit_i (
		.clock            (clock),
		.rstn             (rstn),
		.enable_in        (enable_in),
		.vertex_job       (vertex_job),
		.edge_data_in     (edge_data_in),
		.write_cmd_pop    (write_cmd_pop),
		.write_cmd_out    (write_cmd_out),
		.write_response_in(write_response_in),
		.edge_count       (edge_count),
		.response_count   (response_count)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic int rand_below(input int limit);
		logic [31:0] raw;
		raw = $random(seed);
		return int'(raw % 32'(limit));
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic wait_responses(input int lane, input int target);
		int waited;
		waited = 0;
		@(negedge clock);
		while (int'(response_count[lane]) < target) begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_with_failure($sformatf("Timed out waiting for a write response on lane %0d", lane));
			end
		end
	endtask

	// Expected lane is the one whose open job has this index, the sum settles a tie
	task automatic take_command();
		int              lane;
		write_response_t resp;
		lane = -1;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (model_cmd_open[l] && (model_job_id[l] == write_cmd_out.payload.index) &&
				(lane < 0 || model_job_sum[l] == write_cmd_out.payload.data)) begin
				lane = l;
			end
		end
		if (lane < 0) begin
			stop_with_failure($sformatf(
				"FAIL write_cmd_out.payload.index: got 0x%0h, no open job has that id",
				write_cmd_out.payload.index));
		end
		check_equal("write_cmd_out.payload.lane_id", 32'(write_cmd_out.payload.lane_id),
			32'(lane));
		check_equal("write_cmd_out.payload.data", write_cmd_out.payload.data,
			model_job_sum[lane]);
		model_close_job(lane);
		resp = '{valid: 1'b1, lane_id: write_cmd_out.payload.lane_id,
			index: write_cmd_out.payload.index};
		resp_q.push_back(resp);
		resp_due_q.push_back(cycle_count + 2 + rand_below(4));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic drive_lane(input int lane, input int num_jobs);
		logic [VERTEX_BITS-1:0] id;
		logic [DATA_BITS-1:0]   value;
		int                     degree;
		int                     target;
		for (int job = 0; job < num_jobs; job++) begin
			id     = VERTEX_BITS'(rand_below(1 << VERTEX_BITS));
			degree = 1 + rand_below(12);
			target = model_resps[lane] + 1;
			@(posedge clock);
			vertex_job[lane] <= '{valid: 1'b1, id: id, in_degree: VERTEX_BITS'(degree)};
			model_start_job(lane, id);
			for (int e = 0; e < degree; e++) begin
				value = $random(seed);
				@(posedge clock);
				edge_data_in[lane] <= '{valid: 1'b1, data: value};
				model_add_edge(lane, value);
				@(posedge clock);
				edge_data_in[lane].valid <= 1'b0;
				repeat (rand_below(3)) @(posedge clock);
			end
			// Next job only once the response is back
			wait_responses(lane, target);
		end
	endtask

	task automatic run_phase(input int num_jobs);
		fork
			drive_lane(0, num_jobs);
			drive_lane(1, num_jobs);
		join
	endtask

	// Edges pushed while disabled must sit in the edge buffers
	task automatic check_enable_gating();
		logic [NUM_LANES-1:0][VERTEX_BITS-1:0] edges_held;
		logic [NUM_LANES-1:0][VERTEX_BITS-1:0] resps_held;
		logic [VERTEX_BITS-1:0]                id;
		logic [DATA_BITS-1:0]                  value;
		int                                    degree [NUM_LANES];
		int                                    target [NUM_LANES];
		@(posedge clock);
		enable_in <= 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		edges_held = edge_count;
		resps_held = response_count;
		@(posedge clock);
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			id           = VERTEX_BITS'(rand_below(1 << VERTEX_BITS));
			degree[lane] = 1 + rand_below(12);
			target[lane] = model_resps[lane] + 1;
			vertex_job[lane] <= '{valid: 1'b1, id: id, in_degree: VERTEX_BITS'(degree[lane])};
			model_start_job(lane, id);
		end
		for (int cyc = 0; cyc < 24; cyc++) begin
			@(posedge clock);
			for (int lane = 0; lane < NUM_LANES; lane++) begin
				if (cyc < degree[lane]) begin
					value = $random(seed);
					edge_data_in[lane] <= '{valid: 1'b1, data: value};
					model_add_edge(lane, value);
				end else begin
					edge_data_in[lane].valid <= 1'b0;
				end
			end
			@(negedge clock);
			if (write_cmd_out.valid) begin
				stop_with_failure("A write command came out while enable_in was low");
			end
			for (int lane = 0; lane < NUM_LANES; lane++) begin
				check_equal($sformatf("edge_count[%0d]", lane), 32'(edge_count[lane]),
					32'(edges_held[lane]));
				check_equal($sformatf("response_count[%0d]", lane), 32'(response_count[lane]),
					32'(resps_held[lane]));
			end
		end
		@(posedge clock);
		enable_in <= 1'b1;
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			wait_responses(lane, target[lane]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Responder and monitor
	//////////////////////////////////////////////////////////////////////

	// Pops come only in short windows while hold_pops is set
	initial begin : responder
		logic            pop_open;
		write_response_t next_resp;
		forever begin
			@(posedge clock);
			cycle_count++;
			pop_open = !hold_pops || ((cycle_count % 64) < 6);
			write_cmd_pop <= pop_open && (rand_below(2) == 0);
			if (resp_q.size() > 0 && cycle_count >= resp_due_q[0]) begin
				next_resp = resp_q.pop_front();
				void'(resp_due_q.pop_front());
				write_response_in <= next_resp;
			end else begin
				write_response_in.valid <= 1'b0;
			end
		end
	end

	initial begin : monitor
		forever begin
			@(negedge clock);
			if (rstn) begin
				// Counter already reflects every response seen before this cycle
				for (int lane = 0; lane < NUM_LANES; lane++) begin
					check_equal($sformatf("response_count[%0d]", lane),
						32'(response_count[lane]), 32'(model_resps[lane]));
				end
				if (write_response_in.valid) begin
					model_add_response(int'(write_response_in.lane_id));
				end
				if (write_cmd_out.valid) begin
					take_command();
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rstn              <= 1'b0;
		enable_in         <= 1'b0;
		vertex_job        <= '0;
		edge_data_in      <= '0;
		write_cmd_pop     <= 1'b0;
		write_response_in <= '0;
		hold_pops         = 1'b0;
		model_clear();
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		repeat (2) @(posedge clock);
		enable_in <= 1'b1;
		run_phase(JOBS_PER_PHASE);
		// Long pop holdoffs while both lanes keep working
		hold_pops = 1'b1;
		run_phase(JOBS_PER_PHASE);
		hold_pops = 1'b0;
		check_enable_gating();
		for (int lane = 0; lane < NUM_LANES; lane++) begin
			check_equal($sformatf("edge_count[%0d]", lane), 32'(edge_count[lane]),
				32'(model_edges[lane]));
			check_equal($sformatf("lane %0d command total", lane), 32'(model_cmds[lane]),
				32'(2 * JOBS_PER_PHASE + 1));
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* cu_sum_unit.f */
+incdir+tests
logic/graph_cu_pkg.sv
logic/sync_fifo.sv
logic/sum_kernel_control.sv
logic/write_bus_arbiter.sv
logic/cu_sum_unit.sv
tests/cu_sum_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds the sum unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module cu_sum_unit_tb \
	-Mdir obj_dir \
	-f cu_sum_unit.f

./obj_dir/Vcu_sum_unit_tb
